// File: src/matmul_pkg.sv
`default_nettype none

package matmul_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int DWIDTH        = 8;
  localparam int MAT_SIZE      = 8;
  localparam int LOG2_MAT_SIZE = 3;
  localparam int AWIDTH        = 13;
  localparam int MEM_SIZE      = 8192;
  localparam int ADDR_STEP     = 8;

  // Parked address, the memories hold zeros here
  localparam int IDLE_ADDR = MEM_SIZE - 8;

  ////////////////////////////////////////
  // Timing
  ////////////////////////////////////////

  localparam int NUM_CYCLES_IN_MAC = 3;
  localparam int CNT_WIDTH         = 7;

  // First result row is complete in every cell of row 0
  localparam int ROW_LATCH_COUNT = MAT_SIZE + 10 + NUM_CYCLES_IN_MAC - 1;
  // Systolic run takes 4N - 2 + P cycles plus margin
  localparam int DONE_COUNT      = 4 * MAT_SIZE + 3;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [DWIDTH-1:0]    elem_t;
  typedef logic [2*DWIDTH-1:0]  prod_t;
  // Lane 0 sits in the least significant byte
  typedef elem_t [MAT_SIZE-1:0] lane_vec_t;
  typedef logic [AWIDTH-1:0]    addr_t;
  typedef logic [CNT_WIDTH-1:0] cycle_cnt_t;

endpackage

`default_nettype wire

// File: src/matmul_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_sequencer
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  i_start,
  output logic  o_clear,
  output logic  o_skew_clear,
  output logic  o_row_latch,
  output logic  o_done,
  output addr_t o_a_addr,
  output addr_t o_b_addr
);

  cycle_cnt_t count;
  logic       done_q;
  addr_t      op_addr;

  ////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////

  // Dropping start is the only way to restart a product
  assign o_clear = reset | ~i_start;

  // Skew registers also flush on the first counted cycle
  assign o_skew_clear = o_clear | (count == '0);

  assign o_row_latch = (count == cycle_cnt_t'(ROW_LATCH_COUNT));
  assign o_done      = done_q;

  ////////////////////////////////////////
  // Cycle counter and done flag
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (o_clear) begin
      count  <= '0;
      done_q <= 1'b0;
    end else if (count == cycle_cnt_t'(DONE_COUNT)) begin
      // Count freezes here, done follows one cycle later
      done_q <= 1'b1;
    end else begin
      count <= count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Operand address walk
  ////////////////////////////////////////

  // A columns and B rows share one address
  always_ff @(posedge clk) begin
    if (o_clear) begin
      op_addr <= addr_t'(IDLE_ADDR);
    end else if (count >= cycle_cnt_t'(MAT_SIZE)) begin
      op_addr <= addr_t'(IDLE_ADDR);
    end else begin
      // Wraps from the parked address to 0 on the first step
      op_addr <= op_addr + addr_t'(ADDR_STEP);
    end
  end

  assign o_a_addr = op_addr;
  assign o_b_addr = op_addr;

endmodule

`default_nettype wire

// File: src/operand_skew.sv
`timescale 1ns/10ps
`default_nettype none

module operand_skew
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      i_clear,
  input  lane_vec_t i_lanes,
  output lane_vec_t o_lanes
);

  // Lane 0 enters the array without delay
  assign o_lanes[0] = i_lanes[0];

  // Lane i runs through a chain of i registers
  for (genvar i = 1; i < MAT_SIZE; i++) begin : g_lane
    elem_t dly [0:i-1];

    always_ff @(posedge clk) begin
      if (i_clear) begin
        for (int k = 0; k < i; k++) begin
          dly[k] <= '0;
        end
      end else begin
        dly[0] <= i_lanes[i];
        for (int k = 1; k < i; k++) begin
          dly[k] <= dly[k-1];
        end
      end
    end

    assign o_lanes[i] = dly[i-1];
  end

endmodule

`default_nettype wire

// File: src/mac_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mac_unit
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  i_clear,
  input  elem_t i_a,
  input  elem_t i_b,
  output elem_t o_acc
);

  elem_t a_q;
  elem_t b_q;
  prod_t prod_q;
  elem_t prod_sat;
  elem_t acc;

  // Stage 1 and 2 operand and product registers
  always_ff @(posedge clk) begin
    if (i_clear) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
    end else begin
      a_q    <= i_a;
      b_q    <= i_b;
      prod_q <= prod_t'(a_q) * prod_t'(b_q);
    end
  end

  ////////////////////////////////////////
  // Down-cast of the product to 8 bits
  ////////////////////////////////////////

  always_comb begin
    if (!prod_q[2*DWIDTH-1]) begin
      // Any set bit in 14:7 overflows to the largest positive value
      if (|prod_q[2*DWIDTH-2:DWIDTH-1]) begin
        prod_sat = {1'b0, {(DWIDTH-1){1'b1}}};
      end else begin
        prod_sat = prod_q[DWIDTH-1:0];
      end
    end else begin
      if (|prod_q[2*DWIDTH-2:DWIDTH-1]) begin
        prod_sat = {1'b1, prod_q[DWIDTH-2:0]};
      end else begin
        prod_sat = {1'b1, {(DWIDTH-1){1'b0}}};
      end
    end
  end

  // Stage 3 accumulator, wraps at 8 bits
  always_ff @(posedge clk) begin
    if (i_clear) begin
      acc <= '0;
    end else begin
      acc <= acc + prod_sat;
    end
  end

  assign o_acc = acc;

endmodule

`default_nettype wire

// File: src/processing_element.sv
`timescale 1ns/10ps
`default_nettype none

module processing_element
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  i_clear,
  input  elem_t i_a,
  input  elem_t i_b,
  output elem_t o_a,
  output elem_t o_b,
  output elem_t o_c
);

  // A moves right and B moves down one cell per cycle
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  mac_unit mac0 (
    .clk     (clk),
    .i_clear (i_clear),
    .i_a     (i_a),
    .i_b     (i_b),
    .o_acc   (o_c)
  );

endmodule

`default_nettype wire

// File: src/systolic_array.sv
`timescale 1ns/10ps
`default_nettype none

module systolic_array
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      i_clear,
  input  lane_vec_t i_a_edge,
  input  lane_vec_t i_b_edge,
  output lane_vec_t o_rows [MAT_SIZE]
);

  // One extra column and row catch the values leaving the far edges
  elem_t a_link [MAT_SIZE][MAT_SIZE+1];
  elem_t b_link [MAT_SIZE+1][MAT_SIZE];

  ////////////////////////////////////////
  // Edge feeds
  ////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_edge
    assign a_link[i][0] = i_a_edge[i];
    assign b_link[0][i] = i_b_edge[i];
  end

  ////////////////////////////////////////
  // Cell grid
  ////////////////////////////////////////

  for (genvar r = 0; r < MAT_SIZE; r++) begin : g_row
    for (genvar c = 0; c < MAT_SIZE; c++) begin : g_col
      processing_element pe0 (
        .clk     (clk),
        .i_clear (i_clear),
        .i_a     (a_link[r][c]),
        .i_b     (b_link[r][c]),
        .o_a     (a_link[r][c+1]),
        .o_b     (b_link[r+1][c]),
        .o_c     (o_rows[r][c])
      );
    end
  end

endmodule

`default_nettype wire

// File: src/result_drain.sv
`timescale 1ns/10ps
`default_nettype none

module result_drain
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      i_clear,
  input  logic      i_row_latch,
  input  logic      i_done,
  input  lane_vec_t i_rows [MAT_SIZE],
  output lane_vec_t o_c_data,
  output addr_t     o_c_addr,
  output logic      o_c_available
);

  logic                     capturing;
  logic [LOG2_MAT_SIZE-1:0] row_cnt;

  always_ff @(posedge clk) begin
    if (i_clear) begin
      capturing     <= 1'b0;
      row_cnt       <= '0;
      o_c_available <= 1'b0;
      o_c_addr      <= addr_t'(IDLE_ADDR);
      o_c_data      <= '0;
    end else if (i_row_latch) begin
      // Row 0 goes out first, address steps from parked to 0
      capturing     <= 1'b1;
      row_cnt       <= LOG2_MAT_SIZE'(1);
      o_c_available <= 1'b1;
      o_c_addr      <= o_c_addr + addr_t'(ADDR_STEP);
      o_c_data      <= i_rows[0];
    end else if (i_done) begin
      capturing     <= 1'b0;
      o_c_available <= 1'b0;
      o_c_addr      <= addr_t'(IDLE_ADDR);
      o_c_data      <= '0;
    end else if (capturing) begin
      o_c_available <= 1'b1;
      o_c_addr      <= o_c_addr + addr_t'(ADDR_STEP);
      o_c_data      <= i_rows[row_cnt];
      row_cnt       <= row_cnt + 1'b1;
      // Last row leaves, then the address holds until done
      if (row_cnt == LOG2_MAT_SIZE'(MAT_SIZE - 1)) begin
        capturing <= 1'b0;
      end
    end else begin
      o_c_available <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/matmul_8x8.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_8x8
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      i_start,
  input  lane_vec_t i_a_data,
  input  lane_vec_t i_b_data,
  output addr_t     o_a_addr,
  output addr_t     o_b_addr,
  output addr_t     o_c_addr,
  output lane_vec_t o_c_data,
  output logic      o_c_available,
  output logic      o_done
);

  logic      clear;
  logic      skew_clear;
  logic      row_latch;
  lane_vec_t a_edge;
  lane_vec_t b_edge;
  lane_vec_t c_rows [MAT_SIZE];

  matmul_sequencer seq0 (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .o_clear      (clear),
    .o_skew_clear (skew_clear),
    .o_row_latch  (row_latch),
    .o_done       (o_done),
    .o_a_addr     (o_a_addr),
    .o_b_addr     (o_b_addr)
  );

  ////////////////////////////////////////
  // Wavefront skew for both operands
  ////////////////////////////////////////

  operand_skew skew_a (
    .clk     (clk),
    .i_clear (skew_clear),
    .i_lanes (i_a_data),
    .o_lanes (a_edge)
  );

  operand_skew skew_b (
    .clk     (clk),
    .i_clear (skew_clear),
    .i_lanes (i_b_data),
    .o_lanes (b_edge)
  );

  systolic_array array0 (
    .clk      (clk),
    .i_clear  (clear),
    .i_a_edge (a_edge),
    .i_b_edge (b_edge),
    .o_rows   (c_rows)
  );

  result_drain drain0 (
    .clk           (clk),
    .i_clear       (clear),
    .i_row_latch   (row_latch),
    .i_done        (o_done),
    .i_rows        (c_rows),
    .o_c_data      (o_c_data),
    .o_c_addr      (o_c_addr),
    .o_c_available (o_c_available)
  );

endmodule

`default_nettype wire

// File: bench/matmul_8x8_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_8x8_assertions
  import matmul_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  i_start,
  input addr_t i_c_addr,
  input logic  i_c_available,
  input logic  i_done
);

  // Results are only offered during a run
  c_avail_in_run: assert property (
    @(posedge clk) disable iff (reset) i_c_available |-> i_start
  ) else $error("o_c_available high while i_start is low");

  c_addr_aligned: assert property (
    @(posedge clk) disable iff (reset) i_c_addr[2:0] == 3'b000
  ) else $error("o_c_addr is not a multiple of 8");

  // Done holds until start falls
  done_sticky: assert property (
    @(posedge clk) disable iff (reset) (i_done && i_start) |=> (i_done || !i_start)
  ) else $error("o_done dropped while i_start stayed high");

  avail_done_apart: assert property (
    @(posedge clk) disable iff (reset) !(i_c_available && i_done)
  ) else $error("o_c_available and o_done high together");

endmodule

bind matmul_8x8 matmul_8x8_assertions asrt0 (
  .clk           (clk),
  .reset         (reset),
  .i_start       (i_start),
  .i_c_addr      (o_c_addr),
  .i_c_available (o_c_available),
  .i_done        (o_done)
);

`default_nettype wire

// File: bench/tb_matmul_8x8.sv
`timescale 1ns/10ps
`default_nettype none

module tb_matmul_8x8
  import matmul_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 100;

  logic      clk;
  logic      reset;
  logic      i_start;
  lane_vec_t i_a_data;
  lane_vec_t i_b_data;
  addr_t     o_a_addr;
  addr_t     o_b_addr;
  addr_t     o_c_addr;
  lane_vec_t o_c_data;
  logic      o_c_available;
  logic      o_done;

  elem_t     a_mat [MAT_SIZE][MAT_SIZE];
  elem_t     b_mat [MAT_SIZE][MAT_SIZE];
  lane_vec_t c_got [MAT_SIZE];
  int        c_seen [MAT_SIZE];
  addr_t     a_rd_addr;
  addr_t     b_rd_addr;
  int        err_count;
  int        test_errs;
  int        test_count;
  int        bad_tests;
  bit        aborted;

  matmul_8x8 dut0 (
    .clk           (clk),
    .reset         (reset),
    .i_start       (i_start),
    .i_a_data      (i_a_data),
    .i_b_data      (i_b_data),
    .o_a_addr      (o_a_addr),
    .o_b_addr      (o_b_addr),
    .o_c_addr      (o_c_addr),
    .o_c_data      (o_c_data),
    .o_c_available (o_c_available),
    .o_done        (o_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Memory models and reference
  ////////////////////////////////////////

  // Column k of A or row k of B sits at address 8k, zeros elsewhere
  function automatic lane_vec_t mem_word(bit is_b, addr_t addr);
    lane_vec_t w;
    int        k;
    w = '0;
    k = int'(addr) / ADDR_STEP;
    if (int'(addr) % ADDR_STEP == 0 && k < MAT_SIZE) begin
      for (int l = 0; l < MAT_SIZE; l++) begin
        w[l] = is_b ? b_mat[k][l] : a_mat[l][k];
      end
    end
    return w;
  endfunction

  // Data for an address shows up one cycle after the address
  initial begin
    i_a_data  = '0;
    i_b_data  = '0;
    a_rd_addr = addr_t'(IDLE_ADDR);
    b_rd_addr = addr_t'(IDLE_ADDR);
    forever begin
      @(posedge clk);
      #1;
      i_a_data  = mem_word(1'b0, a_rd_addr);
      i_b_data  = mem_word(1'b1, b_rd_addr);
      a_rd_addr = o_a_addr;
      b_rd_addr = o_b_addr;
    end
  end

  // Product cast down to 8 bits before it is summed
  function automatic elem_t sat_product(int p);
    if (p < 128) begin
      return elem_t'(p);
    end else if (p < 32768) begin
      return 8'h7f;
    end else if ((p & 'h7f80) != 0) begin
      return elem_t'(8'h80 | (p & 'h7f));
    end else begin
      return 8'h80;
    end
  endfunction

  // Sum wraps at 8 bits
  function automatic lane_vec_t ref_row(int r);
    lane_vec_t row;
    elem_t     acc;
    for (int j = 0; j < MAT_SIZE; j++) begin
      acc = '0;
      for (int k = 0; k < MAT_SIZE; k++) begin
        acc = acc + sat_product(int'(a_mat[r][k]) * int'(b_mat[k][j]));
      end
      row[j] = acc;
    end
    return row;
  endfunction

  task automatic fill_random(input int max_val);
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        a_mat[i][j] = elem_t'($urandom_range(max_val, 0));
        b_mat[i][j] = elem_t'($urandom_range(max_val, 0));
      end
    end
  endtask

  ////////////////////////////////////////
  // Checks and bookkeeping
  ////////////////////////////////////////

  task automatic count_error();
    err_count++;
    test_errs++;
  endtask

  task automatic check_row(input string name, input lane_vec_t exp, input lane_vec_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      count_error();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      count_error();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      count_error();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
    count_error();
    aborted = 1'b1;
  endtask

  task automatic close_test(input string name);
    test_count++;
    if (test_errs == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d error(s)", name, test_errs);
      bad_tests++;
    end
    test_errs = 0;
  endtask

  task automatic drive_start(input logic level);
    @(posedge clk);
    #1;
    i_start = level;
  endtask

  // Restarts the DUT, then collects C rows by address until done
  task automatic run_product(input string name);
    int n;
    int row;
    for (int r = 0; r < MAT_SIZE; r++) begin
      c_got[r]  = '0;
      c_seen[r] = 0;
    end
    drive_start(1'b0);
    drive_start(1'b1);
    n = 0;
    while (!o_done && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (o_c_available) begin
        row = int'(o_c_addr) / ADDR_STEP;
        if (row < MAT_SIZE) begin
          c_got[row] = o_c_data;
          c_seen[row]++;
        end
      end
      n++;
    end
    if (!o_done) begin
      report_timeout({name, " o_done"});
    end
  endtask

  task automatic compare_result(input string name, input bit expect_b);
    for (int r = 0; r < MAT_SIZE; r++) begin
      check_row($sformatf("%s row %0d", name, r),
                expect_b ? mem_word(1'b1, addr_t'(r * ADDR_STEP)) : ref_row(r), c_got[r]);
      check_flag($sformatf("%s row %0d seen once", name, r), 1'b1, c_seen[r] == 1);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic idle_after_reset();
    check_flag("idle o_done", 1'b0, o_done);
    check_flag("idle o_c_available", 1'b0, o_c_available);
    check_addr("idle o_a_addr", addr_t'(IDLE_ADDR), o_a_addr);
    check_addr("idle o_b_addr", addr_t'(IDLE_ADDR), o_b_addr);
    check_addr("idle o_c_addr", addr_t'(IDLE_ADDR), o_c_addr);
    close_test("idle");
  endtask

  task automatic operand_addr_walk();
    int    n;
    addr_t exp;
    drive_start(1'b0);
    drive_start(1'b1);
    n = 0;
    while (o_a_addr == addr_t'(IDLE_ADDR) && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (o_a_addr == addr_t'(IDLE_ADDR)) begin
      report_timeout("operand address walk");
    end else begin
      // One address per cycle, then back to the parked address
      for (int k = 0; k <= MAT_SIZE; k++) begin
        exp = (k < MAT_SIZE) ? addr_t'(k * ADDR_STEP) : addr_t'(IDLE_ADDR);
        check_addr($sformatf("addr walk a step %0d", k), exp, o_a_addr);
        check_addr($sformatf("addr walk b step %0d", k), exp, o_b_addr);
        @(negedge clk);
      end
    end
    drive_start(1'b0);
    close_test("addr_walk");
  endtask

  task automatic identity_product();
    // B kept below 128 so that no product saturates
    fill_random(127);
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        a_mat[i][j] = (i == j) ? elem_t'(1) : elem_t'(0);
      end
    end
    run_product("identity");
    if (!aborted) begin
      compare_result("identity", 1'b1);
    end
    close_test("identity");
  endtask

  task automatic random_product(input string name, input int max_val);
    fill_random(max_val);
    run_product(name);
    if (!aborted) begin
      compare_result(name, 1'b0);
    end
    close_test(name);
  endtask

  task automatic restart_product();
    int n;
    drive_start(1'b0);
    n = 0;
    while (o_done && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (o_done) begin
      report_timeout("restart o_done drop");
      close_test("restart");
    end else begin
      check_flag("restart o_c_available", 1'b0, o_c_available);
      check_addr("restart o_c_addr", addr_t'(IDLE_ADDR), o_c_addr);
      random_product("restart", 255);
    end
  endtask

  initial begin
    void'($urandom(45499));
    reset      = 1'b1;
    i_start    = 1'b0;
    err_count  = 0;
    test_errs  = 0;
    test_count = 0;
    bad_tests  = 0;
    aborted    = 1'b0;
    fill_random(0);
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    idle_after_reset();
    operand_addr_walk();
    if (!aborted) begin
      identity_product();
    end
    if (!aborted) begin
      random_product("small", 3);
    end
    if (!aborted) begin
      random_product("saturation", 255);
    end
    if (!aborted) begin
      restart_product();
    end
    $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
             test_count, bad_tests, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: matmul_8x8.f
src/matmul_pkg.sv
src/matmul_sequencer.sv
src/operand_skew.sv
src/mac_unit.sv
src/processing_element.sv
src/systolic_array.sv
src/result_drain.sv
src/matmul_8x8.sv
bench/matmul_8x8_assertions.sv
bench/tb_matmul_8x8.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the matmul_8x8 testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_matmul_8x8 \
  -f matmul_8x8.f \
  --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Build error"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
